//--- verilog/pixel_pkg.sv
package pixel_pkg;

  // ##################################################
  // Types.
  // ##################################################

  typedef logic [9:0] coord_t;
  typedef logic [3:0] score_digit_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  typedef struct packed {
    logic   valid;
    coord_t h_cnt;
    coord_t v_cnt;
  } pixel_t;

  // Top-left corner of one platform.
  typedef struct packed {
    coord_t x;
    coord_t y;
  } platform_t;

  typedef struct packed {
    coord_t       slime_x;
    coord_t       slime_y;
    score_digit_t score_0;
    score_digit_t score_1;
    logic         double_jump;
  } scene_t;

  // ##################################################
  // Sprite geometry and digit strokes.
  // ##################################################

  localparam int SPRITE_W = 20;
  localparam int SPRITE_H = 20;
  localparam int DIGIT_W  = 10;

  // Segment bits, bit 0 is a (top) up to bit 6 which is g (middle).
  localparam logic [9:0][6:0] SEGMENTS = {
    7'h6f, 7'h7f, 7'h07, 7'h7d, 7'h6d,
    7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f
  };

  // ##################################################
  // Palette.
  // ##################################################

  localparam rgb_t INK            = 12'h000;
  localparam rgb_t SLIME_WHITE    = 12'hfff;
  localparam rgb_t SLIME_GREEN    = 12'h1f1;
  localparam rgb_t SLIME_RED      = 12'hf11;
  localparam rgb_t PLATFORM_WHITE = 12'hfff;
  localparam rgb_t PLATFORM_BROWN = 12'hb62;
  localparam rgb_t SKY_BLACK      = 12'h000;
  localparam rgb_t SKY_BLUE       = 12'h8df;

  localparam score_digit_t GREEN_FROM = 4'd2;
  localparam score_digit_t SKY_FROM   = 4'd5;

endpackage

//--- verilog/score_sprite.sv
module score_sprite import pixel_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  pixel_t pixel,
  input  scene_t scene,
  output logic   sprite_hit,
  output logic   sprite_ink
);

  logic         in_x;
  logic         in_y;
  logic [4:0]   col;
  logic [4:0]   row;
  logic [4:0]   k;
  score_digit_t digit;
  logic [6:0]   seg;
  logic         bar;
  logic         left;
  logic         right;
  logic         upper;
  logic         lower;
  logic         ink;

  function automatic logic span(input logic [4:0] v, input int lo, input int hi);
    return (v >= lo) && (v <= hi);
  endfunction

  // ##################################################
  // Sprite box and local coordinates.
  // ##################################################

  always_comb begin
    in_x = (pixel.h_cnt >= scene.slime_x) &&
           ({1'b0, pixel.h_cnt} < {1'b0, scene.slime_x} + 11'(SPRITE_W));
    in_y = (pixel.v_cnt < scene.slime_y) &&
           ({1'b0, pixel.v_cnt} + 11'(SPRITE_H) >= {1'b0, scene.slime_y});
    col  = 5'(pixel.h_cnt - scene.slime_x);
    // Row counts up from the bottom of the sprite.
    row  = 5'(scene.slime_y - pixel.v_cnt - 10'd1);
  end

  // Tens on the left half, ones on the right.
  always_comb begin
    if (col < 5'(DIGIT_W)) begin
      digit = scene.score_1;
      k     = col;
    end else begin
      digit = scene.score_0;
      k     = col - 5'(DIGIT_W);
    end
    if (digit > 4'd9) begin
      digit = 4'd9;
    end
    seg = SEGMENTS[digit];
  end

  // ##################################################
  // Stroke coverage.
  // ##################################################

  always_comb begin
    bar   = span(k, 1, 8);
    left  = span(k, 1, 2);
    right = span(k, 7, 8);
    upper = span(row, 9, 16);
    lower = span(row, 3, 10);
    ink   = (seg[0] && bar && span(row, 15, 16)) ||
            (seg[1] && right && upper) ||
            (seg[2] && right && lower) ||
            (seg[3] && bar && span(row, 3, 4)) ||
            (seg[4] && left && lower) ||
            (seg[5] && left && upper) ||
            (seg[6] && bar && span(row, 9, 10));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sprite_hit <= 1'b0;
      sprite_ink <= 1'b0;
    end else begin
      sprite_hit <= in_x && in_y;
      sprite_ink <= in_x && in_y && ink;
    end
  end

  // Ink only ever lands inside the sprite box.
  ink_inside_sprite: assert property (
    @(posedge clk) disable iff (rst) sprite_ink |-> sprite_hit
  );

endmodule

//--- verilog/platform_layer.sv
module platform_layer import pixel_pkg::*; #(
  parameter int NUM_PLATFORMS = 8,
  parameter int PLATFORM_W    = 40,
  parameter int PLATFORM_H    = 5
) (
  input  logic                          clk,
  input  logic                          rst,
  input  pixel_t                        pixel,
  input  platform_t [NUM_PLATFORMS-1:0] platforms,
  input  logic      [NUM_PLATFORMS-1:0] platform_enable,
  output logic                          platform_hit
);

  logic [NUM_PLATFORMS-1:0] hit_each;
  logic                     hit_any;

  // One box test per platform.
  always_comb begin
    for (int i = 0; i < NUM_PLATFORMS; i++) begin
      hit_each[i] = platform_enable[i] &&
                    (pixel.h_cnt >= platforms[i].x) &&
                    ({1'b0, pixel.h_cnt} < {1'b0, platforms[i].x} + 11'(PLATFORM_W)) &&
                    (pixel.v_cnt >= platforms[i].y) &&
                    ({1'b0, pixel.v_cnt} < {1'b0, platforms[i].y} + 11'(PLATFORM_H));
    end
    hit_any = |hit_each;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      platform_hit <= 1'b0;
    end else begin
      platform_hit <= hit_any;
    end
  end

endmodule

//--- verilog/pixel_mixer.sv
module pixel_mixer import pixel_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  pixel_t pixel,
  input  scene_t scene,
  input  logic   sprite_hit,
  input  logic   sprite_ink,
  input  logic   platform_hit,
  output rgb_t   color,
  output logic   color_valid
);

  logic valid_q;
  logic double_jump_q;
  logic green_q;
  logic sky_q;
  rgb_t sprite_color;
  rgb_t next_color;

  // ##################################################
  // Stage 1, aligned with the renderers.
  // ##################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pixel.valid;
    end
  end

  always_ff @(posedge clk) begin
    double_jump_q <= scene.double_jump;
    green_q       <= scene.score_1 >= GREEN_FROM;
    sky_q         <= scene.score_1 >= SKY_FROM;
  end

  // ##################################################
  // Stage 2, colour select.
  // ##################################################

  always_comb begin
    if (double_jump_q) begin
      sprite_color = SLIME_RED;
    end else if (green_q) begin
      sprite_color = SLIME_GREEN;
    end else begin
      sprite_color = SLIME_WHITE;
    end

    if (!valid_q) begin
      next_color = '0;
    end else if (sprite_hit) begin
      next_color = sprite_ink ? INK : sprite_color;
    end else if (platform_hit) begin
      next_color = sky_q ? PLATFORM_BROWN : PLATFORM_WHITE;
    end else begin
      next_color = sky_q ? SKY_BLUE : SKY_BLACK;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      color       <= '0;
      color_valid <= 1'b0;
    end else begin
      color       <= next_color;
      color_valid <= valid_q;
    end
  end

  // Blanked output is black.
  blank_is_black: assert property (
    @(posedge clk) !color_valid |-> (color == '0)
  );

endmodule

//--- verilog/pixel_gen.sv
module pixel_gen import pixel_pkg::*; #(
  parameter int NUM_PLATFORMS = 8,
  parameter int PLATFORM_W    = 40,
  parameter int PLATFORM_H    = 5
) (
  input  logic                          clk,
  input  logic                          rst,
  input  pixel_t                        pixel,
  input  scene_t                        scene,
  input  platform_t [NUM_PLATFORMS-1:0] platforms,
  input  logic      [NUM_PLATFORMS-1:0] platform_enable,
  output rgb_t                          color,
  output logic                          color_valid
);

  logic sprite_hit;
  logic sprite_ink;
  logic platform_hit;

  score_sprite score_sprite_inst (
    .clk        (clk),
    .rst        (rst),
    .pixel      (pixel),
    .scene      (scene),
    .sprite_hit (sprite_hit),
    .sprite_ink (sprite_ink)
  );

  platform_layer #(
    .NUM_PLATFORMS (NUM_PLATFORMS),
    .PLATFORM_W    (PLATFORM_W),
    .PLATFORM_H    (PLATFORM_H)
  ) platform_layer_inst (
    .clk             (clk),
    .rst             (rst),
    .pixel           (pixel),
    .platforms       (platforms),
    .platform_enable (platform_enable),
    .platform_hit    (platform_hit)
  );

  pixel_mixer pixel_mixer_inst (
    .clk          (clk),
    .rst          (rst),
    .pixel        (pixel),
    .scene        (scene),
    .sprite_hit   (sprite_hit),
    .sprite_ink   (sprite_ink),
    .platform_hit (platform_hit),
    .color        (color),
    .color_valid  (color_valid)
  );

endmodule

//--- sim/pixel_model.svh
`ifndef PIXEL_MODEL_SVH
`define PIXEL_MODEL_SVH

// 32-bit Fibonacci LFSR, taps 32, 22, 2 and 1.
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

// Lit strokes, msb first as a b c d e f g.
function automatic logic [6:0] lit_strokes(input int digit);
  case (digit)
    0:       return 7'b1111110;
    1:       return 7'b0110000;
    2:       return 7'b1101101;
    3:       return 7'b1111001;
    4:       return 7'b0110011;
    5:       return 7'b1011011;
    6:       return 7'b1011111;
    7:       return 7'b1110000;
    8:       return 7'b1111111;
    default: return 7'b1111011;
  endcase
endfunction

// Column k inside the digit cell, row ry counted up from the sprite bottom.
function automatic logic glyph_ink(input int digit, input int k, input int ry);
  logic [6:0] lit;
  logic       bar;
  logic       left;
  logic       right;
  logic       upper;
  logic       lower;
  lit   = lit_strokes(digit);
  bar   = (k >= 1) && (k <= 8);
  left  = (k == 1) || (k == 2);
  right = (k == 7) || (k == 8);
  upper = (ry >= 9) && (ry <= 16);
  lower = (ry >= 3) && (ry <= 10);
  return (lit[6] && bar && (ry == 15 || ry == 16)) ||
         (lit[5] && right && upper) ||
         (lit[4] && right && lower) ||
         (lit[3] && bar && (ry == 3 || ry == 4)) ||
         (lit[2] && left && lower) ||
         (lit[1] && left && upper) ||
         (lit[0] && bar && (ry == 9 || ry == 10));
endfunction

// Expected {color_valid, color} for one sampled pixel.
function automatic logic [12:0] expected_pixel(input pixel_t p, input scene_t s,
    input platform_t [NUM_PLATFORMS-1:0] plats, input logic [NUM_PLATFORMS-1:0] enable);
  int   h;
  int   v;
  int   sx;
  int   sy;
  int   digit;
  int   i;
  logic on_platform;
  logic sky;
  h   = int'(p.h_cnt);
  v   = int'(p.v_cnt);
  sx  = int'(s.slime_x);
  sy  = int'(s.slime_y);
  sky = int'(s.score_1) >= int'(SKY_FROM);
  on_platform = 1'b0;
  for (i = 0; i < NUM_PLATFORMS; i++) begin
    if (enable[i] && h >= int'(plats[i].x) && h < int'(plats[i].x) + PLATFORM_W &&
        v >= int'(plats[i].y) && v < int'(plats[i].y) + PLATFORM_H) begin
      on_platform = 1'b1;
    end
  end
  if (!p.valid) begin
    return 13'h0;
  end
  if (h >= sx && h < sx + SPRITE_W && v < sy && v >= sy - SPRITE_H) begin
    digit = (h - sx < DIGIT_W) ? int'(s.score_1) : int'(s.score_0);
    if (digit > 9) begin
      digit = 9;
    end
    if (glyph_ink(digit, (h - sx) % DIGIT_W, sy - v - 1)) begin
      return {1'b1, INK};
    end
    if (s.double_jump) begin
      return {1'b1, SLIME_RED};
    end
    return (int'(s.score_1) >= int'(GREEN_FROM)) ? {1'b1, SLIME_GREEN} : {1'b1, SLIME_WHITE};
  end
  if (on_platform) begin
    return sky ? {1'b1, PLATFORM_BROWN} : {1'b1, PLATFORM_WHITE};
  end
  return sky ? {1'b1, SKY_BLUE} : {1'b1, SKY_BLACK};
endfunction

`endif

//--- sim/tb_pixel_gen.sv
module tb_pixel_gen import pixel_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PLATFORMS = 8;
  localparam int PLATFORM_W    = 40;
  localparam int PLATFORM_H    = 5;
  localparam int NUM_SCENES    = 200;
  localparam int SCENE_PIXELS  = 64;
  localparam int RESET_LIMIT   = 20;

  bit                            clk;
  logic                          rst;
  pixel_t                        pixel;
  scene_t                        scene;
  platform_t [NUM_PLATFORMS-1:0] platforms;
  logic      [NUM_PLATFORMS-1:0] platform_enable;
  rgb_t                          color;
  logic                          color_valid;

  logic [31:0] lfsr = 32'haf6b;
  logic [12:0] expected_q[$];
  int          checked;

  `include "pixel_model.svh"

  pixel_gen #(
    .NUM_PLATFORMS (NUM_PLATFORMS),
    .PLATFORM_W    (PLATFORM_W),
    .PLATFORM_H    (PLATFORM_H)
  ) pixel_gen_inst (
    .clk             (clk),
    .rst             (rst),
    .pixel           (pixel),
    .scene           (scene),
    .platforms       (platforms),
    .platform_enable (platform_enable),
    .color           (color),
    .color_valid     (color_valid)
  );

  initial begin
    forever begin
      #20 clk = ~clk;
    end
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst         = 1'b0;
    pixel.valid = 1'b0;
  end

  // ##################################################
  // Random helpers.
  // ##################################################

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    repeat (count) begin
      lfsr  = lfsr_step(lfsr);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  task automatic new_scene();
    int i;
    scene.slime_x     = coord_t'(random_bits(10));
    scene.slime_y     = coord_t'(random_bits(9) + 32'd16);
    scene.score_0     = score_digit_t'(random_bits(4));
    scene.score_1     = score_digit_t'(random_bits(4));
    scene.double_jump = random_bits(2) == 0;
    platform_enable   = NUM_PLATFORMS'(random_bits(NUM_PLATFORMS));
    // Platform 0 sits just under the slime, so the two often overlap.
    platforms[0].x = coord_t'(int'(scene.slime_x) - int'(random_bits(5)));
    platforms[0].y = coord_t'(int'(scene.slime_y) - int'(random_bits(5)));
    for (i = 1; i < NUM_PLATFORMS; i++) begin
      platforms[i].x = coord_t'(random_bits(10));
      platforms[i].y = coord_t'(random_bits(9));
    end
  endtask

  // Mostly around the slime or a platform, a quarter blanked.
  function automatic pixel_t random_pixel();
    pixel_t p;
    int     mode;
    int     pick;
    mode    = int'(random_bits(2));
    pick    = int'(random_bits(3));
    p.valid = random_bits(2) != 0;
    case (mode)
      0, 1: begin
        p.h_cnt = coord_t'(int'(scene.slime_x) + int'(random_bits(5)) - 6);
        p.v_cnt = coord_t'(int'(scene.slime_y) - int'(random_bits(5)) + 4);
      end
      2: begin
        p.h_cnt = coord_t'(int'(platforms[pick].x) + int'(random_bits(6)) - 10);
        p.v_cnt = coord_t'(int'(platforms[pick].y) + int'(random_bits(4)) - 5);
      end
      default: begin
        p.h_cnt = coord_t'(random_bits(10));
        p.v_cnt = coord_t'(random_bits(10));
      end
    endcase
    return p;
  endfunction

  // ##################################################
  // Checking.
  // ##################################################

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "Output does not match the expected value");
    end
  endtask

  task automatic check_oldest();
    logic [12:0] expected;
    expected = expected_q.pop_front();
    compare_value($sformatf("output %0d", checked), 32'(expected), 32'({color_valid, color}));
    checked++;
  endtask

  initial begin
    int wait_cycles;
    int n;
    pixel           = '0;
    // A valid pixel held through reset must not reach the output.
    pixel.valid     = 1'b1;
    scene           = '0;
    platforms       = '0;
    platform_enable = '0;
    checked         = 0;
    wait_cycles     = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > RESET_LIMIT) begin
        $display("Reset did not finish within %0d clock cycles", RESET_LIMIT);
        $display("Test failed");
        $fatal(1, "Reset timeout");
      end
    end
    @(negedge clk);
    compare_value("reset_hold", 32'h0, 32'({color_valid, color}));
    // The pixel sampled on the first edge out of reset was blanked.
    expected_q.push_back(13'h0);
    for (n = 0; n < NUM_SCENES * SCENE_PIXELS; n++) begin
      if (n % SCENE_PIXELS == 0) begin
        new_scene();
      end
      pixel = random_pixel();
      expected_q.push_back(expected_pixel(pixel, scene, platforms, platform_enable));
      @(negedge clk);
      check_oldest();
    end
    pixel = '0;
    while (expected_q.size() > 0) begin
      @(negedge clk);
      check_oldest();
    end
    $display("Test passed");
    $finish;
  end

endmodule

//--- all.f
+incdir+sim
verilog/pixel_pkg.sv
verilog/score_sprite.sv
verilog/platform_layer.sv
verilog/pixel_mixer.sv
verilog/pixel_gen.sv
sim/tb_pixel_gen.sv

//--- Makefile
# Verilator build and run for the pixel generator testbench.

TOP = tb_pixel_gen

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	  -f all.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee run.log
	@grep -qx "Test passed" run.log || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf obj_dir run.log
